//--- Makefile
SIM  := obj_dir/Vtb_wb_subsys
SRCS := $(wildcard include/*.svh src/*.sv dv/*.sv)

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^SIMULATION PASSED$$"

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_subsys -f all.f

clean:
	rm -rf obj_dir

//--- all.f
+incdir+include
src/wb_pkg.sv
src/mem_bus_if.sv
src/write_buffer.sv
src/line_fetcher.sv
src/mem_arbiter.sv
src/wb_subsys_top.sv
dv/mem_model.sv
dv/tb_wb_subsys.sv

//--- dv/mem_model.sv
// behavioral memory with random command delay and beat gaps, reporting each write burst
`timescale 1ns/10ps
`include "wb_params.svh"

module mem_model (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     stall,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     we,
    input  logic [31:0]              addr,
    input  logic [`WB_WORD_BITS-1:0] wdata,
    output logic [`WB_WORD_BITS-1:0] rdata,
    output logic                     beat,
    output logic                     wr_done,
    output logic [31:0]              wr_addr,
    output wb_pkg::line_t            wr_line,
    output int                       wr_count
);
    import wb_pkg::*;

    localparam int WORDS = `WB_LINE_WORDS;
    localparam int OFS   = `WB_OFFSET_BITS;

    line_t store [logic [31-OFS:0]];

    // unwritten words read back a pattern of their byte address
    function automatic logic [31:0] read_word(input logic [31-OFS:0] key, input int i);
        if (store.exists(key)) begin
            return store[key][i];
        end
        return {key, OFS'(i * 4)} ^ 32'h5bd1_e995;
    endfunction

    initial begin
        logic [31-OFS:0] key;
        logic [31:0]     cmd_addr;
        logic            is_wr;
        line_t           line;
        int              gap;
        cmd_ready = 1'b0;
        beat      = 1'b0;
        rdata     = '0;
        wr_done   = 1'b0;
        wr_addr   = '0;
        wr_line   = '0;
        wr_count  = 0;
        forever begin
            @(posedge clk);
            if (rstn && cmd_valid) begin
                repeat ($urandom_range(3, 0)) @(posedge clk);
                while (stall) @(posedge clk);
                #2 cmd_ready = 1'b1;
                @(posedge clk);
                cmd_addr = addr;
                key      = addr[31:OFS];
                is_wr    = we;
                line     = '0;
                #2 cmd_ready = 1'b0;
                for (int i = 0; i < WORDS; i++) begin
                    gap = $urandom_range(2, 0);
                    if (gap != 0) begin
                        repeat (gap) @(posedge clk);
                        #2;
                    end
                    rdata = is_wr ? '0 : read_word(key, i);
                    beat  = 1'b1;
                    @(posedge clk);
                    if (is_wr) begin
                        line[i] = wdata;
                    end
                    #2 beat = 1'b0;
                end
                // one-cycle report of the finished write
                if (is_wr) begin
                    store[key] = line;
                    wr_addr    = cmd_addr;
                    wr_line    = line;
                    wr_count   = wr_count + 1;
                    wr_done    = 1'b1;
                    @(posedge clk);
                    #2 wr_done = 1'b0;
                end
            end
        end
    end

endmodule

//--- dv/tb_wb_subsys.sv
// testbench for the write buffer subsystem, checking fills and drains against a reference model
`timescale 1ns/10ps
`include "wb_params.svh"

module tb_wb_subsys;
    import wb_pkg::*;

    localparam int WORDS      = `WB_LINE_WORDS;
    localparam int DEPTH      = `WB_DEPTH;
    localparam int OFS        = `WB_OFFSET_BITS;
    localparam int LN         = 32 - OFS;
    localparam int N_LINES    = 6;
    localparam int N_OPS      = 40;
    // directed steps plus the final readback
    localparam int EXTRA_OPS  = 20;
    // a full queue ahead of an operation plus its own burst
    localparam int WAIT_BOUND = 120;

    logic                     clk;
    logic                     rstn;
    logic                     evict_valid;
    line_addr_u               evict_addr;
    line_t                    evict_line;
    logic                     evict_ack;
    logic                     miss_valid;
    line_addr_u               miss_addr;
    logic                     fill_valid;
    line_t                    fill_line;
    logic                     mem_cmd_valid;
    logic                     mem_cmd_ready;
    logic                     mem_we;
    logic [31:0]              mem_addr;
    logic [`WB_WORD_BITS-1:0] mem_wdata;
    logic [`WB_WORD_BITS-1:0] mem_rdata;
    logic                     mem_beat;
    logic                     stall;
    logic                     wr_done;
    logic [31:0]              wr_addr;
    line_t                    wr_line;
    int                       wr_count;

    logic [LN-1:0] pool [N_LINES];
    // newest value per line which memory holds once drained
    line_t         ref_line [N_LINES];
    // accepted evictions not yet written in arrival order
    int            exp_idx [$];
    line_t         exp_line [$];
    int            acked = 0;
    int            drained = 0;
    int            beats_left;

    wb_subsys_top uut (
        .clk (clk), .rstn (rstn),
        .evict_valid (evict_valid), .evict_addr (evict_addr),
        .evict_line (evict_line), .evict_ack (evict_ack),
        .miss_valid (miss_valid), .miss_addr (miss_addr),
        .fill_valid (fill_valid), .fill_line (fill_line),
        .mem_cmd_valid (mem_cmd_valid), .mem_cmd_ready (mem_cmd_ready),
        .mem_we (mem_we), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata), .mem_beat (mem_beat)
    );

    mem_model u_mem (
        .clk (clk), .rstn (rstn), .stall (stall),
        .cmd_valid (mem_cmd_valid), .cmd_ready (mem_cmd_ready),
        .we (mem_we), .addr (mem_addr), .wdata (mem_wdata),
        .rdata (mem_rdata), .beat (mem_beat),
        .wr_done (wr_done), .wr_addr (wr_addr), .wr_line (wr_line), .wr_count (wr_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    initial begin
        repeat ((N_OPS + EXTRA_OPS) * WAIT_BOUND) @(posedge clk);
        fail_run("timeout: the run did not finish within its cycle budget");
    end

    function automatic line_t init_line(input int idx);
        line_t l;
        for (int w = 0; w < WORDS; w++) begin
            l[w] = {pool[idx], OFS'(w * 4)} ^ 32'h5bd1_e995;
        end
        return l;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int w = 0; w < WORDS; w++) begin
            l[w] = $urandom;
        end
        return l;
    endfunction

    function automatic bit in_flight(input int idx);
        foreach (exp_idx[k]) begin
            if (exp_idx[k] == idx) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // bursts of exactly WORDS beats and strobes only when asked for
    always @(posedge clk) begin
        if (!rstn) begin
            beats_left = 0;
        end else begin
            if (beats_left != 0) begin
                assert (!mem_cmd_valid) else fail_run("a new command was issued during a burst");
            end
            if (mem_cmd_valid && mem_cmd_ready) begin
                beats_left = WORDS;
            end
            if (mem_beat) begin
                assert (beats_left != 0) else fail_run("a beat arrived with no burst running");
                beats_left--;
            end
            assert (!evict_ack || evict_valid) else fail_run("evict_ack with no eviction pending");
            assert (!fill_valid || miss_valid) else fail_run("fill_valid with no miss outstanding");
        end
    end

    // each write burst must be the oldest accepted eviction
    always @(posedge clk) begin
        if (rstn && wr_done) begin
            assert (exp_idx.size() != 0) else fail_run("a write burst with no eviction pending");
            assert (wr_addr[31:OFS] === pool[exp_idx[0]])
                else fail_run($sformatf("mismatch mem_addr line: got %h expected %h",
                                        wr_addr[31:OFS], pool[exp_idx[0]]));
            assert (wr_line === exp_line[0])
                else fail_run($sformatf("mismatch mem_wdata burst: got %h expected %h",
                                        wr_line, exp_line[0]));
            void'(exp_idx.pop_front());
            void'(exp_line.pop_front());
            drained++;
        end
    end

    task automatic evict_start(input int idx, input line_t data);
        evict_addr.f.line_num = pool[idx];
        evict_addr.f.offset   = OFS'($urandom);
        evict_line            = data;
        evict_valid           = 1'b1;
    endtask

    task automatic evict_finish(input int idx, input line_t data);
        do begin
            @(posedge clk);
        end while (!evict_ack);
        ref_line[idx] = data;
        exp_idx.push_back(idx);
        exp_line.push_back(data);
        acked++;
        #2 evict_valid = 1'b0;
    endtask

    task automatic evict(input int idx, input line_t data);
        evict_start(idx, data);
        evict_finish(idx, data);
    endtask

    task automatic miss_start(input int idx);
        miss_addr.f.line_num = pool[idx];
        miss_addr.f.offset   = OFS'($urandom);
        miss_valid           = 1'b1;
    endtask

    task automatic miss_finish(input int idx);
        string src;
        do begin
            @(posedge clk);
        end while (!fill_valid);
        src = in_flight(idx) ? "forwarded" : "memory read";
        assert (fill_line === ref_line[idx])
            else fail_run($sformatf("mismatch fill_line (%s): got %h expected %h",
                                    src, fill_line, ref_line[idx]));
        #2 miss_valid = 1'b0;
    endtask

    task automatic miss(input int idx);
        miss_start(idx);
        miss_finish(idx);
    endtask

    task automatic wait_drained();
        while (acked != drained) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        logic [31:0] base;
        line_t       data;
        int          idx;
        int          writes_before;
        void'($urandom(32'h729a));
        rstn        = 1'b0;
        evict_valid = 1'b0;
        evict_addr  = '0;
        evict_line  = '0;
        miss_valid  = 1'b0;
        miss_addr   = '0;
        stall       = 1'b0;
        base        = $urandom;
        for (int i = 0; i < N_LINES; i++) begin
            pool[i]     = LN'(base) + LN'(i * 5);
            ref_line[i] = init_line(i);
        end

        repeat (4) @(posedge clk);
        assert (!evict_ack && !fill_valid && !mem_cmd_valid)
            else fail_run("evict_ack, fill_valid or mem_cmd_valid high during reset");
        #2 rstn = 1'b1;

        // fill the queue with line 0 evicted twice
        stall = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            evict(i % 3, rand_line());
        end
        data = rand_line();
        evict_start(0, data);
        repeat (10) begin
            @(posedge clk);
            assert (!evict_ack) else fail_run("evict_ack given while the queue was full");
        end
        writes_before = wr_count;
        #2 stall = 1'b0;
        evict_finish(0, data);
        assert (wr_count > writes_before) else fail_run("eviction taken before a drain made room");
        miss(0);
        wait_drained();

        // write drain and read miss compete for the port
        stall = 1'b1;
        evict(1, rand_line());
        miss_start(5);
        repeat (3) @(posedge clk);
        #2 stall = 1'b0;
        miss_finish(5);
        wait_drained();

        for (int n = 0; n < N_OPS; n++) begin
            idx = $urandom_range(N_LINES - 1, 0);
            if ($urandom_range(99, 0) < 60) begin
                evict(idx, rand_line());
            end else begin
                miss(idx);
            end
        end

        // memory must now hold the newest copy of every line
        wait_drained();
        for (int i = 0; i < N_LINES; i++) begin
            miss(i);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- include/wb_params.svh
// write buffer subsystem sizing: queue depth, line geometry and word width
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// entries in the eviction queue
`define WB_DEPTH 4

// words per line, also the burst length
`define WB_LINE_WORDS 4

`define WB_OFFSET_BITS 4
`define WB_WORD_BITS 32

`endif

//--- src/line_fetcher.sv
// line fetcher: serves read misses from the write buffer or by a burst read from memory
`timescale 1ns/10ps
`include "wb_params.svh"

module line_fetcher (
    input  logic               clk,
    input  logic               rstn,
    input  logic               miss_valid,
    input  wb_pkg::line_addr_u miss_addr,
    output logic               fill_valid,
    output wb_pkg::line_t      fill_line,
    output wb_pkg::line_addr_u query_addr,
    input  logic               query_hit,
    input  wb_pkg::line_t      query_line,
    mem_bus_if.requester       mem
);
    import wb_pkg::*;

    localparam int WORDS  = `WB_LINE_WORDS;
    localparam int BEAT_W = $clog2(WORDS);

    typedef enum logic [1:0] {
        LF_IDLE,
        LF_CMD,
        LF_BEATS
    } fetch_state_e;

    fetch_state_e      state;
    logic [BEAT_W-1:0] beat_cnt;
    logic              new_miss;
    logic              take_hit;
    logic              last_beat;

    // miss_valid stays up through the fill cycle
    assign new_miss  = (state == LF_IDLE) && miss_valid && !fill_valid;
    assign take_hit  = new_miss && query_hit;
    assign last_beat = (beat_cnt == BEAT_W'(WORDS - 1));

    assign query_addr    = miss_addr;
    assign mem.cmd_valid = (state == LF_CMD);
    assign mem.we        = 1'b0;
    assign mem.addr      = miss_addr;
    assign mem.wdata     = '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= LF_IDLE;
            beat_cnt   <= '0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                LF_IDLE: begin
                    if (take_hit) begin
                        fill_valid <= 1'b1;
                    end else if (new_miss) begin
                        state <= LF_CMD;
                    end
                end
                LF_CMD: begin
                    if (mem.cmd_ready) begin
                        state    <= LF_BEATS;
                        beat_cnt <= '0;
                    end
                end
                LF_BEATS: begin
                    if (mem.beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state      <= LF_IDLE;
                            fill_valid <= 1'b1;
                        end
                    end
                end
                default: state <= LF_IDLE;
            endcase
        end
    end

    // gather words by beat index, or take the buffered copy whole
    always_ff @(posedge clk) begin
        if (take_hit) begin
            fill_line <= query_line;
        end else if (state == LF_BEATS && mem.beat) begin
            fill_line[beat_cnt] <= mem.rdata;
        end
    end

    a_fill_has_miss: assert property (@(posedge clk) disable iff (!rstn)
        fill_valid |-> miss_valid && $past(miss_valid));

endmodule

//--- src/mem_arbiter.sv
// round-robin arbiter sharing one memory port between two burst requesters
`timescale 1ns/10ps
`include "wb_params.svh"

module mem_arbiter (
    input  logic                     clk,
    input  logic                     rstn,
    mem_bus_if.arbiter               req [2],
    output logic                     mem_cmd_valid,
    input  logic                     mem_cmd_ready,
    output logic                     mem_we,
    output logic [31:0]              mem_addr,
    output logic [`WB_WORD_BITS-1:0] mem_wdata,
    input  logic [`WB_WORD_BITS-1:0] mem_rdata,
    input  logic                     mem_beat
);
    import wb_pkg::*;

    localparam int NREQ   = 2;
    localparam int WORDS  = `WB_LINE_WORDS;
    localparam int BEAT_W = $clog2(WORDS);

    logic [NREQ-1:0]          req_valid;
    logic [NREQ-1:0]          req_we;
    line_addr_u               req_addr [NREQ];
    logic [`WB_WORD_BITS-1:0] req_wdata [NREQ];
    req_id_t                  prio;
    req_id_t                  pick;
    req_id_t                  sel;
    req_id_t                  owner;
    logic                     hold;
    logic                     in_burst;
    logic                     burst_end;
    logic [BEAT_W-1:0]        beat_cnt;

    for (genvar i = 0; i < NREQ; i++) begin : g_req
        assign req_valid[i] = req[i].cmd_valid;
        assign req_we[i]    = req[i].we;
        assign req_addr[i]  = req[i].addr;
        assign req_wdata[i] = req[i].wdata;

        assign req[i].cmd_ready = (sel == req_id_t'(i)) && !in_burst
                                  && req[i].cmd_valid && mem_cmd_ready;
        assign req[i].beat      = (sel == req_id_t'(i)) && in_burst && mem_beat;
        assign req[i].rdata     = mem_rdata;
    end

    assign pick = (req_valid[prio] || !req_valid[~prio]) ? prio : ~prio;
    // choice is frozen once a command is shown, so addr stays put while waiting
    assign sel  = hold ? owner : pick;

    assign mem_cmd_valid = !in_burst && req_valid[sel];
    assign mem_we        = req_we[sel];
    assign mem_addr      = req_addr[sel].raw;
    assign mem_wdata     = req_wdata[sel];
    assign burst_end     = in_burst && mem_beat && (beat_cnt == BEAT_W'(WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            hold     <= 1'b0;
            in_burst <= 1'b0;
            owner    <= '0;
            prio     <= '0;
            beat_cnt <= '0;
        end else if (!in_burst) begin
            if (mem_cmd_valid) begin
                hold  <= 1'b1;
                owner <= sel;
            end
            if (mem_cmd_valid && mem_cmd_ready) begin
                in_burst <= 1'b1;
                beat_cnt <= '0;
            end
        end else if (mem_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (burst_end) begin
                in_burst <= 1'b0;
                hold     <= 1'b0;
                prio     <= ~owner;
            end
        end
    end

    a_owner_stable: assert property (@(posedge clk) disable iff (!rstn)
        in_burst && !burst_end |=> in_burst && $stable(owner));

endmodule

//--- src/mem_bus_if.sv
// memory bus interface between one requester and the round-robin arbiter
`timescale 1ns/10ps
`include "wb_params.svh"

interface mem_bus_if;
    import wb_pkg::*;

    logic                     cmd_valid;
    logic                     cmd_ready;
    logic                     we;
    line_addr_u               addr;
    logic [`WB_WORD_BITS-1:0] wdata;
    logic [`WB_WORD_BITS-1:0] rdata;
    // one word done per pulse
    logic                     beat;

    modport requester (
        output cmd_valid, we, addr, wdata,
        input  cmd_ready, rdata, beat
    );

    modport arbiter (
        input  cmd_valid, we, addr, wdata,
        output cmd_ready, rdata, beat
    );

endinterface

//--- src/wb_pkg.sv
// write buffer subsystem types: line address views, cache line and requester index
`include "wb_params.svh"

package wb_pkg;

    typedef struct packed {
        logic [31-`WB_OFFSET_BITS:0] line_num;
        logic [`WB_OFFSET_BITS-1:0]  offset;
    } line_fields_t;

    // raw view goes on the bus, field view is used for matching
    typedef union packed {
        logic [31:0]  raw;
        line_fields_t f;
    } line_addr_u;

    typedef logic [`WB_LINE_WORDS-1:0][`WB_WORD_BITS-1:0] line_t;

    typedef logic [0:0] req_id_t;

endpackage

//--- src/wb_subsys_top.sv
// write buffer subsystem top: eviction queue, line fetcher and memory arbiter
`timescale 1ns/10ps
`include "wb_params.svh"

module wb_subsys_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     evict_valid,
    input  wb_pkg::line_addr_u       evict_addr,
    input  wb_pkg::line_t            evict_line,
    output logic                     evict_ack,
    input  logic                     miss_valid,
    input  wb_pkg::line_addr_u       miss_addr,
    output logic                     fill_valid,
    output wb_pkg::line_t            fill_line,
    output logic                     mem_cmd_valid,
    input  logic                     mem_cmd_ready,
    output logic                     mem_we,
    output logic [31:0]              mem_addr,
    output logic [`WB_WORD_BITS-1:0] mem_wdata,
    input  logic [`WB_WORD_BITS-1:0] mem_rdata,
    input  logic                     mem_beat
);
    import wb_pkg::*;

    // requester slots on the arbiter
    localparam req_id_t REQ_WB = 1'b0;
    localparam req_id_t REQ_LF = 1'b1;

    line_addr_u query_addr;
    logic       query_hit;
    line_t      query_line;

    mem_bus_if bus [2] ();

    write_buffer u_write_buffer (
        .clk         (clk),
        .rstn        (rstn),
        .evict_valid (evict_valid),
        .evict_addr  (evict_addr),
        .evict_line  (evict_line),
        .evict_ack   (evict_ack),
        .query_addr  (query_addr),
        .query_hit   (query_hit),
        .query_line  (query_line),
        .mem         (bus[REQ_WB])
    );

    line_fetcher u_line_fetcher (
        .clk        (clk),
        .rstn       (rstn),
        .miss_valid (miss_valid),
        .miss_addr  (miss_addr),
        .fill_valid (fill_valid),
        .fill_line  (fill_line),
        .query_addr (query_addr),
        .query_hit  (query_hit),
        .query_line (query_line),
        .mem        (bus[REQ_LF])
    );

    mem_arbiter u_mem_arbiter (
        .clk           (clk),
        .rstn          (rstn),
        .req           (bus),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .mem_beat      (mem_beat)
    );

endmodule

//--- src/write_buffer.sv
// write buffer: shift-in queue of evicted lines with address query and in-order burst drain
`timescale 1ns/10ps
`include "wb_params.svh"

module write_buffer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               evict_valid,
    input  wb_pkg::line_addr_u evict_addr,
    input  wb_pkg::line_t      evict_line,
    output logic               evict_ack,
    input  wb_pkg::line_addr_u query_addr,
    output logic               query_hit,
    output wb_pkg::line_t      query_line,
    mem_bus_if.requester       mem
);
    import wb_pkg::*;

    localparam int DEPTH  = `WB_DEPTH;
    localparam int WORDS  = `WB_LINE_WORDS;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int BEAT_W = $clog2(WORDS);

    typedef enum logic [1:0] {
        DR_IDLE,
        DR_CMD,
        DR_BEATS,
        DR_DONE
    } drain_state_e;

    line_addr_u        entry_addr [DEPTH];
    line_t             entry_line [DEPTH];
    logic [CNT_W-1:0]  count;
    logic [PTR_W-1:0]  oldest;
    logic [BEAT_W-1:0] beat_cnt;
    drain_state_e      state;
    logic              do_insert;
    logic              last_beat;
    logic              retire;

    // newest at 0, oldest at count-1
    assign oldest    = (count == '0) ? '0 : PTR_W'(count - 1'b1);
    // ack cycle still sees evict_valid, so skip it
    assign do_insert = evict_valid && !evict_ack && (count != CNT_W'(DEPTH));
    assign last_beat = (beat_cnt == BEAT_W'(WORDS - 1));
    assign retire    = (state == DR_BEATS) && mem.beat && last_beat;

    always_ff @(posedge clk) begin
        if (do_insert) begin
            entry_addr[0] <= evict_addr;
            entry_line[0] <= evict_line;
            for (int i = 1; i < DEPTH; i++) begin
                entry_addr[i] <= entry_addr[i-1];
                entry_line[i] <= entry_line[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count     <= '0;
            evict_ack <= 1'b0;
        end else begin
            evict_ack <= do_insert;
            if (do_insert && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !do_insert) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= DR_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                DR_IDLE: begin
                    if (count != '0) begin
                        state <= DR_CMD;
                    end
                end
                DR_CMD: begin
                    if (mem.cmd_ready) begin
                        state    <= DR_BEATS;
                        beat_cnt <= '0;
                    end
                end
                DR_BEATS: begin
                    if (mem.beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= DR_DONE;
                        end
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    assign mem.cmd_valid = (state == DR_CMD);
    assign mem.we        = 1'b1;
    assign mem.addr      = entry_addr[oldest];
    assign mem.wdata     = entry_line[oldest][beat_cnt];

    // scan oldest to newest so the newest match is left standing
    always_comb begin
        query_hit  = 1'b0;
        query_line = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (i < count && entry_addr[i].f.line_num == query_addr.f.line_num) begin
                query_hit  = 1'b1;
                query_line = entry_line[i];
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= CNT_W'(DEPTH));

    a_ack_single: assert property (@(posedge clk) disable iff (!rstn)
        evict_ack |=> !evict_ack);

endmodule
